// ==== gpu_pkg.sv ====
package gpu_pkg;

    // ====================
    // Field widths
    // ====================

    localparam int REG_ADDR_W = 7;
    localparam int REG_DATA_W = 64;

    // Host register bus
    typedef logic [REG_ADDR_W-1:0] reg_addr_t;
    typedef logic [REG_DATA_W-1:0] reg_data_t;

    // Packed command: {rw, addr, data}, rw set means read
    typedef logic [REG_ADDR_W+REG_DATA_W:0] cmd_word_t;

    // Memory side, half-word addressing
    typedef logic [23:0] mem_addr_t;
    typedef logic [31:0] mem_data_t;
    typedef logic [19:0] fill_count_t;

    // Timestamp target, word address
    typedef logic [22:0] ts_addr_t;

    // ====================
    // Register map
    // ====================

    localparam reg_addr_t REG_MEM_FILL  = 7'h10;
    localparam reg_addr_t REG_TIMESTAMP = 7'h11;
    localparam reg_addr_t REG_STATUS    = 7'h7E;
    localparam reg_addr_t REG_ID        = 7'h7F;

    localparam reg_data_t GPU_ID = 64'h0000_4750_0002_0000;

    // MEM_FILL layout: base [15:0], value [31:16], count [51:32]
    localparam int FILL_VALUE_LSB = 16;
    localparam int FILL_COUNT_LSB = 32;

    // 512-byte units to half-word address
    localparam int BASE_SHIFT = 8;

endpackage

// ==== gpu_cmd_fifo.sv ====
`timescale 1ns/100ps

module gpu_cmd_fifo #(
    parameter int CMD_FIFO_DEPTH      = 16,
    parameter int CMD_ALMOST_FULL_GAP = 4
) (
    input  logic              clk_core,
    input  logic              rst_n_core,
    input  logic              push,
    input  gpu_pkg::cmd_word_t push_data,
    input  logic              pop,
    output gpu_pkg::cmd_word_t head,
    output logic              empty,
    output logic              almost_full
);

    import gpu_pkg::*;

    localparam int PTR_W = $clog2(CMD_FIFO_DEPTH);
    localparam int CNT_W = $clog2(CMD_FIFO_DEPTH + 1);

    // Storage, no reset needed on the entries
    cmd_word_t mem [CMD_FIFO_DEPTH];

    logic [PTR_W-1:0] wr_ptr_q;
    logic [PTR_W-1:0] rd_ptr_q;
    logic [CNT_W-1:0] count_q;
    logic             full;
    logic             do_push;
    logic             do_pop;

    assign full    = (count_q == CNT_W'(CMD_FIFO_DEPTH));
    assign empty   = (count_q == '0);
    // Push into a full FIFO is dropped
    assign do_push = push && !full;
    assign do_pop  = pop && !empty;

    // Host is expected to back off once this rises
    assign almost_full = (count_q >= CNT_W'(CMD_FIFO_DEPTH - CMD_ALMOST_FULL_GAP));

    // Head read straight from the array
    assign head = mem[rd_ptr_q];

    always_ff @(posedge clk_core) begin
        if (do_push) begin
            mem[wr_ptr_q] <= push_data;
        end
    end

    // Pointers wrap at depth, also for non power-of-two depths
    always_ff @(posedge clk_core or negedge rst_n_core) begin
        if (!rst_n_core) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr_q <= (wr_ptr_q == PTR_W'(CMD_FIFO_DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
            end
            if (do_pop) begin
                rd_ptr_q <= (rd_ptr_q == PTR_W'(CMD_FIFO_DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
            end
            // Level tracks the net change
            if (do_push && !do_pop) begin
                count_q <= count_q + 1'b1;
            end else if (do_pop && !do_push) begin
                count_q <= count_q - 1'b1;
            end
        end
    end

endmodule

// ==== gpu_reg_decode.sv ====
`timescale 1ns/100ps

module gpu_reg_decode (
    input  logic                 clk_core,
    input  logic                 rst_n_core,
    input  gpu_pkg::cmd_word_t   head,
    input  logic                 empty,
    output logic                 pop,
    output logic                 rdata_valid,
    output gpu_pkg::reg_data_t   rdata,
    output logic                 fill_start,
    output gpu_pkg::mem_addr_t   fill_base,
    output logic [15:0]          fill_value,
    output gpu_pkg::fill_count_t fill_count,
    input  logic                 fill_busy,
    output logic                 ts_write,
    output gpu_pkg::ts_addr_t    ts_addr,
    output gpu_pkg::mem_data_t   ts_value,
    input  logic                 ts_pending
);

    import gpu_pkg::*;

    logic      head_rw;
    reg_addr_t head_addr;
    reg_data_t head_data;
    logic      is_fill_wr;
    logic      is_ts_wr;
    logic      stall;
    logic      head_seen_q;
    reg_data_t mem_fill_q;
    mem_data_t cycle_cnt_q;

    // ====================
    // Head unpack and stall
    // ====================

    assign {head_rw, head_addr, head_data} = head;

    assign is_fill_wr = !head_rw && (head_addr == REG_MEM_FILL);
    assign is_ts_wr   = !head_rw && (head_addr == REG_TIMESTAMP);

    // Hold the head while its target engine is still working
    assign stall = (is_fill_wr && fill_busy) || (is_ts_wr && ts_pending);

    // Head must have been visible one full cycle before it goes
    assign pop = !empty && head_seen_q && !stall;

    always_ff @(posedge clk_core or negedge rst_n_core) begin
        if (!rst_n_core) begin
            head_seen_q <= 1'b0;
        end else begin
            head_seen_q <= !empty && !pop;
        end
    end

    // ====================
    // Triggers
    // ====================

    assign fill_start = pop && is_fill_wr;
    assign fill_base  = mem_addr_t'(head_data[15:0]) << BASE_SHIFT;
    assign fill_value = head_data[FILL_VALUE_LSB +: 16];
    assign fill_count = head_data[FILL_COUNT_LSB +: $bits(fill_count_t)];

    assign ts_write = pop && is_ts_wr;
    assign ts_addr  = head_data[$bits(ts_addr_t)-1:0];
    // Timestamp is the counter value in the pop cycle
    assign ts_value = cycle_cnt_q;

    always_ff @(posedge clk_core or negedge rst_n_core) begin
        if (!rst_n_core) begin
            mem_fill_q  <= '0;
            cycle_cnt_q <= '0;
        end else begin
            cycle_cnt_q <= cycle_cnt_q + 1'b1;
            // Keep last MEM_FILL for readback
            if (fill_start) begin
                mem_fill_q <= head_data;
            end
        end
    end

    // ====================
    // Readback
    // ====================

    assign rdata_valid = pop && head_rw;

    always_comb begin
        case (head_addr)
            REG_MEM_FILL: rdata = mem_fill_q;
            REG_ID:       rdata = GPU_ID;
            REG_STATUS:   rdata = {62'd0, ts_pending, fill_busy};
            default:      rdata = '0;
        endcase
    end

endmodule

// ==== gpu_fill_engine.sv ====
`timescale 1ns/100ps

module gpu_fill_engine (
    input  logic                 clk_core,
    input  logic                 rst_n_core,
    input  logic                 fill_start,
    input  gpu_pkg::mem_addr_t   fill_base,
    input  logic [15:0]          fill_value,
    input  gpu_pkg::fill_count_t fill_count,
    output logic                 fill_busy,
    output logic                 fill_req,
    output gpu_pkg::mem_addr_t   fill_addr,
    output gpu_pkg::mem_data_t   fill_data,
    input  logic                 fill_ack
);

    import gpu_pkg::*;

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_REQUEST,
        ST_WAIT_ACK
    } fill_state_t;

    fill_state_t state_q;
    fill_count_t remain_q;
    mem_addr_t   addr_q;
    logic [15:0] value_q;

    // Request held from first cycle of a word until its ack
    assign fill_busy = (state_q != ST_IDLE);
    assign fill_req  = (state_q != ST_IDLE);
    assign fill_addr = addr_q;
    // Same 16-bit value in both halves
    assign fill_data = {value_q, value_q};

    always_ff @(posedge clk_core or negedge rst_n_core) begin
        if (!rst_n_core) begin
            state_q  <= ST_IDLE;
            remain_q <= '0;
        end else begin
            case (state_q)
                ST_IDLE: begin
                    // Zero count never leaves idle
                    if (fill_start && (fill_count != '0)) begin
                        state_q  <= ST_REQUEST;
                        remain_q <= fill_count;
                    end
                end
                // First cycle of a word, ack cannot come yet
                ST_REQUEST: state_q <= ST_WAIT_ACK;
                ST_WAIT_ACK: begin
                    if (fill_ack) begin
                        remain_q <= remain_q - 1'b1;
                        state_q  <= (remain_q == fill_count_t'(1)) ? ST_IDLE : ST_REQUEST;
                    end
                end
                default: state_q <= ST_IDLE;
            endcase
        end
    end

    // Word address steps by two half-words
    always_ff @(posedge clk_core) begin
        if (state_q == ST_IDLE && fill_start) begin
            addr_q  <= fill_base;
            value_q <= fill_value;
        end else if (state_q == ST_WAIT_ACK && fill_ack) begin
            addr_q <= addr_q + mem_addr_t'(2);
        end
    end

endmodule

// ==== gpu_mem_port.sv ====
`timescale 1ns/100ps

module gpu_mem_port (
    input  logic               clk_core,
    input  logic               rst_n_core,
    input  logic               ts_write,
    input  gpu_pkg::ts_addr_t  ts_addr,
    input  gpu_pkg::mem_data_t ts_value,
    output logic               ts_pending,
    input  logic               fill_req,
    input  gpu_pkg::mem_addr_t fill_addr,
    input  gpu_pkg::mem_data_t fill_data,
    output logic               fill_ack,
    output logic               mem_req,
    output gpu_pkg::mem_addr_t mem_addr,
    output gpu_pkg::mem_data_t mem_wdata,
    input  logic               mem_ack
);

    import gpu_pkg::*;

    mem_addr_t ts_addr_q;
    mem_data_t ts_data_q;
    logic      req_q;
    logic      owner_ts_q;
    mem_addr_t addr_q;
    mem_data_t data_q;

    assign mem_req   = req_q;
    assign mem_addr  = addr_q;
    assign mem_wdata = data_q;

    // Ack goes back to the fill engine only for its own word
    assign fill_ack = mem_ack && req_q && !owner_ts_q;

    // ====================
    // Request ownership
    // ====================

    always_ff @(posedge clk_core or negedge rst_n_core) begin
        if (!rst_n_core) begin
            ts_pending <= 1'b0;
            req_q      <= 1'b0;
            owner_ts_q <= 1'b0;
        end else begin
            // Latch and hold until the timestamp word is accepted
            if (ts_write) begin
                ts_pending <= 1'b1;
            end else if (ts_pending && req_q && owner_ts_q && mem_ack) begin
                ts_pending <= 1'b0;
            end
            if (req_q) begin
                // Drop for at least one cycle after the ack
                if (mem_ack) begin
                    req_q <= 1'b0;
                end
            end else if (ts_pending || fill_req) begin
                req_q      <= 1'b1;
                // Timestamp slips in between fill words
                owner_ts_q <= ts_pending;
            end
        end
    end

    // Payload, frozen while the request is out
    always_ff @(posedge clk_core) begin
        if (ts_write) begin
            ts_addr_q <= {ts_addr, 1'b0};
            ts_data_q <= ts_value;
        end
        if (!req_q) begin
            addr_q <= ts_pending ? ts_addr_q : fill_addr;
            data_q <= ts_pending ? ts_data_q : fill_data;
        end
    end

endmodule

// ==== gpu_cmd_top.sv ====
`timescale 1ns/100ps

module gpu_cmd_top #(
    parameter int CMD_FIFO_DEPTH      = 16,
    parameter int CMD_ALMOST_FULL_GAP = 4
) (
    input  logic               clk_core,
    input  logic               rst_n_core,
    // Host register bus
    input  logic               cmd_valid,
    input  logic               cmd_rw,
    input  gpu_pkg::reg_addr_t cmd_addr,
    input  gpu_pkg::reg_data_t cmd_wdata,
    output logic               rdata_valid,
    output gpu_pkg::reg_data_t rdata,
    output logic               cmd_almost_full,
    output logic               cmd_empty,
    // Memory write port
    output logic               mem_req,
    output gpu_pkg::mem_addr_t mem_addr,
    output gpu_pkg::mem_data_t mem_wdata,
    input  logic               mem_ack
);

    import gpu_pkg::*;

    cmd_word_t   cmd_word;
    cmd_word_t   head;
    logic        pop;
    logic        fill_start;
    mem_addr_t   fill_base;
    logic [15:0] fill_value;
    fill_count_t fill_count;
    logic        fill_busy;
    logic        fill_req;
    mem_addr_t   fill_addr;
    mem_data_t   fill_data;
    logic        fill_ack;
    logic        ts_write;
    ts_addr_t    ts_addr;
    mem_data_t   ts_value;
    logic        ts_pending;

    // Host command packed as {rw, addr, data}
    assign cmd_word = {cmd_rw, cmd_addr, cmd_wdata};

    gpu_cmd_fifo #(
        .CMD_FIFO_DEPTH     (CMD_FIFO_DEPTH),
        .CMD_ALMOST_FULL_GAP(CMD_ALMOST_FULL_GAP)
    ) gpu_cmd_fifo_inst (
        .clk_core   (clk_core),
        .rst_n_core (rst_n_core),
        .push       (cmd_valid),
        .push_data  (cmd_word),
        .pop        (pop),
        .head       (head),
        .empty      (cmd_empty),
        .almost_full(cmd_almost_full)
    );

    gpu_reg_decode gpu_reg_decode_inst (
        .clk_core   (clk_core),
        .rst_n_core (rst_n_core),
        .head       (head),
        .empty      (cmd_empty),
        .pop        (pop),
        .rdata_valid(rdata_valid),
        .rdata      (rdata),
        .fill_start (fill_start),
        .fill_base  (fill_base),
        .fill_value (fill_value),
        .fill_count (fill_count),
        .fill_busy  (fill_busy),
        .ts_write   (ts_write),
        .ts_addr    (ts_addr),
        .ts_value   (ts_value),
        .ts_pending (ts_pending)
    );

    gpu_fill_engine gpu_fill_engine_inst (
        .clk_core  (clk_core),
        .rst_n_core(rst_n_core),
        .fill_start(fill_start),
        .fill_base (fill_base),
        .fill_value(fill_value),
        .fill_count(fill_count),
        .fill_busy (fill_busy),
        .fill_req  (fill_req),
        .fill_addr (fill_addr),
        .fill_data (fill_data),
        .fill_ack  (fill_ack)
    );

    gpu_mem_port gpu_mem_port_inst (
        .clk_core  (clk_core),
        .rst_n_core(rst_n_core),
        .ts_write  (ts_write),
        .ts_addr   (ts_addr),
        .ts_value  (ts_value),
        .ts_pending(ts_pending),
        .fill_req  (fill_req),
        .fill_addr (fill_addr),
        .fill_data (fill_data),
        .fill_ack  (fill_ack),
        .mem_req   (mem_req),
        .mem_addr  (mem_addr),
        .mem_wdata (mem_wdata),
        .mem_ack   (mem_ack)
    );

endmodule

// ==== gpu_cmd_props.sv ====
`timescale 1ns/100ps

module gpu_cmd_props #(
    parameter int DEPTH = 16
) (
    input logic               clk_core,
    input logic               rst_n_core,
    input logic               cmd_valid,
    input logic               pop,
    input logic               rdata_valid,
    input logic               mem_req,
    input logic               mem_ack,
    input gpu_pkg::mem_addr_t mem_addr,
    input gpu_pkg::mem_data_t mem_wdata
);

    // Shadow fill level of the command FIFO
    int level_q;

    always_ff @(posedge clk_core or negedge rst_n_core) begin
        if (!rst_n_core) begin
            level_q <= 0;
        end else begin
            case ({cmd_valid && (level_q < DEPTH), pop && (level_q > 0)})
                2'b10:   level_q <= level_q + 1;
                2'b01:   level_q <= level_q - 1;
                default: level_q <= level_q;
            endcase
        end
    end

    // ====================
    // Memory port
    // ====================

    // Payload frozen until ack
    assert property (@(posedge clk_core) disable iff (!rst_n_core)
        mem_req && !mem_ack |=> mem_req && $stable(mem_addr) && $stable(mem_wdata))
        else $error("mem_req dropped or payload changed before mem_ack");

    assert property (@(posedge clk_core) disable iff (!rst_n_core)
        mem_req && mem_ack |=> !mem_req)
        else $error("mem_req not low in the cycle after mem_ack");

    // ====================
    // Host port
    // ====================

    assert property (@(posedge clk_core) disable iff (!rst_n_core)
        rdata_valid |=> !rdata_valid)
        else $error("rdata_valid high for two cycles running");

    assert property (@(posedge clk_core) disable iff (!rst_n_core)
        !(cmd_valid && (level_q == DEPTH)))
        else $error("Command pushed while the command FIFO is full");

endmodule

bind gpu_cmd_top gpu_cmd_props #(
    .DEPTH(CMD_FIFO_DEPTH)
) gpu_cmd_props_inst (
    .clk_core   (clk_core),
    .rst_n_core (rst_n_core),
    .cmd_valid  (cmd_valid),
    .pop        (pop),
    .rdata_valid(rdata_valid),
    .mem_req    (mem_req),
    .mem_ack    (mem_ack),
    .mem_addr   (mem_addr),
    .mem_wdata  (mem_wdata)
);

// ==== tb_gpu_cmd.sv ====
`timescale 1ns/100ps

module tb_gpu_cmd;

    import gpu_pkg::*;

    localparam int CLK_PERIOD      = 20;
    localparam int FIFO_DEPTH      = 16;
    localparam int AF_GAP          = 4;
    localparam int NUM_TESTS       = 6;
    localparam int CYCLES_PER_TEST = 2000;
    localparam int WAIT_LIMIT      = 1000;

    logic      clk_core;
    logic      rst_n_core;
    logic      cmd_valid;
    logic      cmd_rw;
    reg_addr_t cmd_addr;
    reg_data_t cmd_wdata;
    logic      rdata_valid;
    reg_data_t rdata;
    logic      cmd_almost_full;
    logic      cmd_empty;
    logic      mem_req;
    mem_addr_t mem_addr;
    mem_data_t mem_wdata;
    logic      mem_ack;

    // Responder mode and write log
    logic      slow_ack;
    mem_addr_t wr_addr_log[$];
    mem_data_t wr_data_log[$];
    mem_addr_t exp_addr[$];
    mem_data_t exp_data[$];

    gpu_cmd_top #(
        .CMD_FIFO_DEPTH     (FIFO_DEPTH),
        .CMD_ALMOST_FULL_GAP(AF_GAP)
    ) gpu_cmd_top_inst (
        .clk_core       (clk_core),
        .rst_n_core     (rst_n_core),
        .cmd_valid      (cmd_valid),
        .cmd_rw         (cmd_rw),
        .cmd_addr       (cmd_addr),
        .cmd_wdata      (cmd_wdata),
        .rdata_valid    (rdata_valid),
        .rdata          (rdata),
        .cmd_almost_full(cmd_almost_full),
        .cmd_empty      (cmd_empty),
        .mem_req        (mem_req),
        .mem_addr       (mem_addr),
        .mem_wdata      (mem_wdata),
        .mem_ack        (mem_ack)
    );

    always #(CLK_PERIOD / 2) clk_core = ~clk_core;

    // ====================
    // Memory responder
    // ====================

    // Ack after a random wait and log each completed word
    initial begin
        int ack_delay;
        forever begin
            @(negedge clk_core);
            if (rst_n_core && mem_req) begin
                ack_delay = slow_ack ? 6 + int'($urandom % 4) : int'($urandom % 4);
                repeat (ack_delay) @(negedge clk_core);
                wr_addr_log.push_back(mem_addr);
                wr_data_log.push_back(mem_wdata);
                mem_ack = 1'b1;
                @(negedge clk_core);
                mem_ack = 1'b0;
            end
        end
    end

    // ====================
    // Helpers
    // ====================

    task automatic stop_on_error(input string why);
        $display("%s", why);
        $display("TEST RESULT: FAIL");
        $fatal(1, "Run stopped at first error");
    endtask

    task automatic check_value(input string name, input logic [63:0] got,
                               input logic [63:0] exp);
        assert (got === exp) else begin
            stop_on_error($sformatf("Mismatch at %0t: %s got 0x%0h, expected 0x%0h",
                                    $time, name, got, exp));
        end
    endtask

    task automatic check_true(input logic cond, input string what);
        assert (cond === 1'b1) else begin
            stop_on_error($sformatf("At %0t: %s", $time, what));
        end
    endtask

    // One-cycle strobe held off while the FIFO is almost full
    task automatic send_cmd(input logic rw, input reg_addr_t addr, input reg_data_t data);
        int waited;
        waited = 0;
        @(negedge clk_core);
        while (cmd_almost_full) begin
            @(negedge clk_core);
            waited++;
            if (waited > WAIT_LIMIT) begin
                stop_on_error("cmd_almost_full never dropped, command could not be sent");
            end
        end
        cmd_valid = 1'b1;
        cmd_rw    = rw;
        cmd_addr  = addr;
        cmd_wdata = data;
        @(negedge clk_core);
        cmd_valid = 1'b0;
    endtask

    task automatic read_reg(input reg_addr_t addr, output reg_data_t data);
        int waited;
        waited = 0;
        send_cmd(1'b1, addr, '0);
        while (!rdata_valid) begin
            @(negedge clk_core);
            waited++;
            if (waited > WAIT_LIMIT) begin
                stop_on_error($sformatf("Read of address 0x%0h never returned data", addr));
            end
        end
        data = rdata;
    endtask

    // Status reads zero once fill and timestamp are both done
    task automatic wait_idle();
        reg_data_t status;
        int        tries;
        tries = 0;
        read_reg(REG_STATUS, status);
        while (status != '0) begin
            tries++;
            if (tries > 200) begin
                stop_on_error("Fill or timestamp write never finished");
            end
            read_reg(REG_STATUS, status);
        end
    endtask

    // MEM_FILL word with base in [15:0], value in [31:16] and count in [51:32]
    function automatic reg_data_t fill_word(input logic [15:0] base, input logic [15:0] value,
                                            input fill_count_t count);
        return {12'd0, count, value, base};
    endfunction

    function automatic void add_expected_fill(input logic [15:0] base,
                                              input logic [15:0] value, input int count);
        for (int i = 0; i < count; i++) begin
            exp_addr.push_back(mem_addr_t'({base, 8'h00}) + mem_addr_t'(2 * i));
            exp_data.push_back({value, value});
        end
    endfunction

    function automatic void clear_logs();
        wr_addr_log.delete();
        wr_data_log.delete();
        exp_addr.delete();
        exp_data.delete();
    endfunction

    task automatic compare_log();
        check_value("write count", 64'(wr_addr_log.size()), 64'(exp_addr.size()));
        for (int i = 0; i < exp_addr.size(); i++) begin
            check_value($sformatf("mem_addr[%0d]", i), 64'(wr_addr_log[i]), 64'(exp_addr[i]));
            check_value($sformatf("mem_wdata[%0d]", i), 64'(wr_data_log[i]),
                        64'(exp_data[i]));
        end
    endtask

    // ====================
    // Directed tests
    // ====================

    task automatic test_reset_and_id();
        reg_data_t data;
        check_value("cmd_empty", 64'(cmd_empty), 64'(1));
        check_value("cmd_almost_full", 64'(cmd_almost_full), 64'(0));
        check_value("mem_req", 64'(mem_req), 64'(0));
        check_value("rdata_valid", 64'(rdata_valid), 64'(0));
        read_reg(REG_ID, data);
        check_value("rdata REG_ID", data, GPU_ID);
        // Unmapped register
        read_reg(7'h05, data);
        check_value("rdata unused", data, 64'(0));
    endtask

    task automatic test_single_fill();
        logic [15:0] base;
        logic [15:0] value;
        int          count;
        reg_data_t   data;
        base  = 16'($urandom);
        value = 16'($urandom);
        count = 1 + int'($urandom % 8);
        clear_logs();
        add_expected_fill(base, value, count);
        send_cmd(1'b0, REG_MEM_FILL, fill_word(base, value, fill_count_t'(count)));
        wait_idle();
        compare_log();
        read_reg(REG_MEM_FILL, data);
        check_value("rdata REG_MEM_FILL", data, fill_word(base, value, fill_count_t'(count)));
    endtask

    task automatic test_zero_fill();
        reg_data_t data;
        clear_logs();
        send_cmd(1'b0, REG_MEM_FILL, fill_word(16'h1234, 16'hBEEF, '0));
        read_reg(REG_STATUS, data);
        check_value("rdata REG_STATUS", data, 64'(0));
        repeat (20) @(negedge clk_core);
        check_value("write count", 64'(wr_addr_log.size()), 64'(0));
        check_value("mem_req", 64'(mem_req), 64'(0));
    endtask

    task automatic test_timestamps();
        ts_addr_t a1;
        ts_addr_t a2;
        a1 = ts_addr_t'($urandom);
        a2 = ts_addr_t'($urandom);
        clear_logs();
        send_cmd(1'b0, REG_TIMESTAMP, reg_data_t'(a1));
        send_cmd(1'b0, REG_TIMESTAMP, reg_data_t'(a2));
        wait_idle();
        check_value("write count", 64'(wr_addr_log.size()), 64'(2));
        check_value("mem_addr[0]", 64'(wr_addr_log[0]), 64'({a1, 1'b0}));
        check_value("mem_addr[1]", 64'(wr_addr_log[1]), 64'({a2, 1'b0}));
        check_true(wr_data_log[1] > wr_data_log[0], "Second timestamp is not larger");
    endtask

    task automatic test_ts_during_fill();
        logic [15:0] base;
        logic [15:0] value;
        ts_addr_t    ts_a;
        int          ts_idx;
        int          hits;
        // Fill below the midpoint and timestamp above it
        base   = 16'($urandom) & 16'h7FFF;
        value  = 16'($urandom);
        ts_a   = ts_addr_t'($urandom) | 23'h40_0000;
        ts_idx = -1;
        hits   = 0;
        clear_logs();
        add_expected_fill(base, value, 24);
        send_cmd(1'b0, REG_MEM_FILL, fill_word(base, value, fill_count_t'(24)));
        send_cmd(1'b0, REG_TIMESTAMP, reg_data_t'(ts_a));
        wait_idle();
        for (int i = 0; i < wr_addr_log.size(); i++) begin
            if (wr_addr_log[i] == {ts_a, 1'b0}) begin
                ts_idx = i;
                hits++;
            end
        end
        check_value("timestamp write count", 64'(hits), 64'(1));
        check_true(ts_idx > 0 && ts_idx < 24, "Timestamp did not land between fill words");
        wr_addr_log.delete(ts_idx);
        wr_data_log.delete(ts_idx);
        compare_log();
    endtask

    task automatic test_fifo_backpressure();
        logic [15:0] base;
        logic [15:0] value;
        int          pushed;
        logic        saw_af;
        pushed   = 0;
        saw_af   = 1'b0;
        slow_ack = 1'b1;
        clear_logs();
        // One fill per cycle until the host must back off
        while (pushed < FIFO_DEPTH + 4 && !saw_af) begin
            @(negedge clk_core);
            cmd_valid = 1'b0;
            if (cmd_almost_full) begin
                saw_af = 1'b1;
            end else begin
                base      = 16'(16 * (pushed + 1));
                value     = 16'hA500 + 16'(pushed);
                cmd_valid = 1'b1;
                cmd_rw    = 1'b0;
                cmd_addr  = REG_MEM_FILL;
                cmd_wdata = fill_word(base, value, fill_count_t'(2));
                add_expected_fill(base, value, 2);
                pushed++;
            end
        end
        cmd_valid = 1'b0;
        check_true(saw_af, "cmd_almost_full never rose during the fill burst");
        check_true(pushed < FIFO_DEPTH, "FIFO filled before cmd_almost_full rose");
        wait_idle();
        slow_ack = 1'b0;
        compare_log();
        @(negedge clk_core);
        check_value("cmd_empty", 64'(cmd_empty), 64'(1));
    endtask

    // ====================
    // Main sequence
    // ====================

    initial begin
        clk_core    = 1'b0;
        rst_n_core  = 1'b0;
        cmd_valid   = 1'b0;
        cmd_rw      = 1'b0;
        cmd_addr    = '0;
        cmd_wdata   = '0;
        mem_ack     = 1'b0;
        slow_ack    = 1'b0;
        void'($urandom(32'h4783));
        repeat (5) @(posedge clk_core);
        @(negedge clk_core);
        rst_n_core = 1'b1;

        test_reset_and_id();
        test_single_fill();
        test_zero_fill();
        test_timestamps();
        test_ts_during_fill();
        test_fifo_backpressure();

        $display("TEST RESULT: PASS");
        $finish;
    end

    // Budget per directed test
    initial begin
        #(NUM_TESTS * CYCLES_PER_TEST * CLK_PERIOD);
        stop_on_error("Watchdog expired before the tests finished");
    end

endmodule

// ==== files.f ====
gpu_pkg.sv
gpu_cmd_fifo.sv
gpu_reg_decode.sv
gpu_fill_engine.sv
gpu_mem_port.sv
gpu_cmd_top.sv
gpu_cmd_props.sv
tb_gpu_cmd.sv

// ==== run.sh ====
#!/bin/sh
# Build with Verilator, run, and judge the result from the log
rm -rf obj_dir sim.log
verilator --binary --timing --assert -f files.f --top-module tb_gpu_cmd \
    || { echo "Verilator build failed"; exit 1; }
./obj_dir/Vtb_gpu_cmd > sim.log 2>&1
cat sim.log
grep -q "TEST RESULT: FAIL" sim.log && { echo "Simulation failed"; exit 1; }
grep -q "TEST RESULT: PASS" sim.log || { echo "No pass result in log"; exit 1; }
echo "Simulation passed"
exit 0
